//--- logic/ppc_pkg.sv
`default_nettype none

package ppc_pkg;

    localparam int RS_ID_WIDTH = 6;

    // Big-endian bit numbering as in the PowerPC books
    typedef logic [0:31] word_t;
    typedef logic [0:4] reg_addr_t;
    typedef logic [0:RS_ID_WIDTH-1] rs_id_t;
    typedef logic [0:5] opcode_t;
    typedef logic [0:9] ext_opcode_t;

    // Primary opcodes
    localparam opcode_t OPC_ADDI = 6'd14;
    localparam opcode_t OPC_ORI = 6'd24;
    localparam opcode_t OPC_XORI = 6'd26;
    localparam opcode_t OPC_EXT = 6'd31;

    // Extended opcodes under primary opcode 31
    localparam ext_opcode_t XO_ADD = 10'd266;
    localparam ext_opcode_t XO_SUBF = 10'd40;
    localparam ext_opcode_t XO_AND = 10'd28;
    localparam ext_opcode_t XO_OR = 10'd444;
    localparam ext_opcode_t XO_XOR = 10'd316;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ADD_SUB,
        UNIT_LOG
    } unit_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUBF,
        OP_AND,
        OP_OR,
        OP_XOR
    } fx_op_e;

    typedef struct packed {
        unit_e unit;
        fx_op_e op;
        reg_addr_t op1_addr;
        reg_addr_t op2_addr;
        reg_addr_t result_addr;
        logic op2_use_imm;
        logic op1_is_zero;
        word_t immediate;
    } decode_t;

    // rs_id names the producer while valid is low
    typedef struct packed {
        word_t value;
        logic valid;
        rs_id_t rs_id;
    } operand_t;

    typedef struct packed {
        logic valid;
        rs_id_t rs_id;
        reg_addr_t result_addr;
        word_t value;
    } result_bus_t;

    typedef struct packed {
        rs_id_t rs_id;
        reg_addr_t result_addr;
        word_t value;
    } unit_result_t;

endpackage

`default_nettype wire

//--- logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import ppc_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,

    input wire logic instruction_valid,
    output logic instruction_ready,
    input wire word_t instruction,

    output logic decode_valid,
    input wire logic decode_ready,
    output decode_t decode
);

    opcode_t opcode;
    ext_opcode_t ext_opcode;
    reg_addr_t rt;
    reg_addr_t ra;
    reg_addr_t rb;
    decode_t decode_d;

    assign opcode = instruction[0:5];
    assign rt = instruction[6:10];
    assign ra = instruction[11:15];
    assign rb = instruction[16:20];
    assign ext_opcode = instruction[21:30];

    always_comb begin
        decode_d = '0;
        decode_d.unit = UNIT_NONE;
        decode_d.op = OP_ADD;
        // Logical forms take RS in bits 6:10 and write RA
        decode_d.op1_addr = rt;
        decode_d.op2_addr = rb;
        decode_d.result_addr = ra;
        decode_d.immediate = {16'h0000, instruction[16:31]};
        case (opcode)
            OPC_ADDI: begin
                decode_d.unit = UNIT_ADD_SUB;
                decode_d.op1_addr = ra;
                decode_d.result_addr = rt;
                decode_d.op2_use_imm = 1'b1;
                decode_d.op1_is_zero = (ra == 5'd0);
                decode_d.immediate = {{16{instruction[16]}}, instruction[16:31]};
            end
            OPC_ORI: begin
                decode_d.unit = UNIT_LOG;
                decode_d.op = OP_OR;
                decode_d.op2_use_imm = 1'b1;
            end
            OPC_XORI: begin
                decode_d.unit = UNIT_LOG;
                decode_d.op = OP_XOR;
                decode_d.op2_use_imm = 1'b1;
            end
            OPC_EXT: begin
                // OE sits in bit 21 of XO-form and is ignored
                if ({1'b0, ext_opcode[1:9]} == XO_ADD || {1'b0, ext_opcode[1:9]} == XO_SUBF) begin
                    decode_d.unit = UNIT_ADD_SUB;
                    decode_d.op = ({1'b0, ext_opcode[1:9]} == XO_SUBF) ? OP_SUBF : OP_ADD;
                    decode_d.op1_addr = ra;
                    decode_d.result_addr = rt;
                end else if (ext_opcode == XO_AND) begin
                    decode_d.unit = UNIT_LOG;
                    decode_d.op = OP_AND;
                end else if (ext_opcode == XO_OR) begin
                    decode_d.unit = UNIT_LOG;
                    decode_d.op = OP_OR;
                end else if (ext_opcode == XO_XOR) begin
                    decode_d.unit = UNIT_LOG;
                    decode_d.op = OP_XOR;
                end
            end
            default: ;
        endcase
    end

    assign instruction_ready = ~decode_valid | decode_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_valid <= 1'b0;
        end else if (instruction_ready) begin
            decode_valid <= instruction_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instruction_valid && instruction_ready) begin
            decode <= decode_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module dispatcher
    import ppc_pkg::*;
(
    input wire logic decode_valid,
    output logic decode_ready,
    input wire decode_t decode,

    output logic add_sub_valid,
    input wire logic add_sub_ready,
    input wire rs_id_t add_sub_id,

    output logic log_valid,
    input wire logic log_ready,
    input wire rs_id_t log_id,

    output logic gpr_update_enable,
    output reg_addr_t gpr_update_addr,
    output rs_id_t gpr_update_rs_id
);

    assign gpr_update_addr = decode.result_addr;

    always_comb begin
        add_sub_valid = 1'b0;
        log_valid = 1'b0;
        // Unsupported words are simply dropped
        decode_ready = 1'b1;
        gpr_update_enable = 1'b0;
        gpr_update_rs_id = add_sub_id;
        case (decode.unit)
            UNIT_ADD_SUB: begin
                decode_ready = add_sub_ready;
                add_sub_valid = decode_valid & add_sub_ready;
                gpr_update_enable = decode_valid & add_sub_ready;
            end
            UNIT_LOG: begin
                decode_ready = log_ready;
                log_valid = decode_valid & log_ready;
                gpr_update_enable = decode_valid & log_ready;
                gpr_update_rs_id = log_id;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/gp_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module gp_reg_file
    import ppc_pkg::*;
(
    input wire logic clk,
    input wire logic rst_n,

    input wire reg_addr_t read_addr_a,
    input wire reg_addr_t read_addr_b,
    output operand_t read_a,
    output operand_t read_b,

    input wire logic update_enable,
    input wire reg_addr_t update_addr,
    input wire rs_id_t update_rs_id,

    input wire result_bus_t result
);

    word_t value [32];
    logic [31:0] valid;
    rs_id_t tag [32];

    // Same-cycle bus write is forwarded to the reader
    function automatic operand_t read_port(reg_addr_t addr);
        operand_t o;
        o.value = value[addr];
        o.valid = valid[addr];
        o.rs_id = tag[addr];
        if (!o.valid && result.valid && result.result_addr == addr
                && result.rs_id == o.rs_id) begin
            o.value = result.value;
            o.valid = 1'b1;
        end
        return o;
    endfunction

    always_comb begin
        read_a = read_port(read_addr_a);
        read_b = read_port(read_addr_b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                value[i] <= '0;
                valid[i] <= 1'b1;
                tag[i] <= '0;
            end
        end else begin
            // Only the producer the register still waits for may write it
            if (result.valid && tag[result.result_addr] == result.rs_id) begin
                value[result.result_addr] <= result.value;
                valid[result.result_addr] <= 1'b1;
            end
            // Later assignment, so a new tag beats a bus write
            if (update_enable) begin
                valid[update_addr] <= 1'b0;
                tag[update_addr] <= update_rs_id;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/fx_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fx_unit
    import ppc_pkg::*;
#(
    parameter int RS_DEPTH = 8,
    parameter int RS_OFFSET = 0,
    parameter unit_e UNIT = UNIT_ADD_SUB
) (
    input wire logic clk,
    input wire logic rst_n,

    input wire logic issue_valid,
    output logic unit_ready,
    output rs_id_t free_id,
    input wire fx_op_e op,
    input wire reg_addr_t result_addr,
    input wire operand_t op1,
    input wire operand_t op2,

    input wire result_bus_t snoop,

    output logic out_valid,
    input wire logic out_ready,
    output unit_result_t out
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    typedef logic [IDX_W-1:0] idx_t;

    logic [RS_DEPTH-1:0] busy;
    fx_op_e op_q [RS_DEPTH];
    reg_addr_t addr_q [RS_DEPTH];
    operand_t op1_q [RS_DEPTH];
    operand_t op2_q [RS_DEPTH];

    idx_t free_idx;
    idx_t sel_idx;
    logic any_ready;
    logic alloc;
    logic issue;
    logic held;
    operand_t op1_in;
    operand_t op2_in;
    word_t opa;
    word_t opb;
    fx_op_e sel_op;
    word_t res;

    function automatic operand_t capture(operand_t o, result_bus_t bus);
        operand_t r;
        r = o;
        if (!o.valid && bus.valid && bus.rs_id == o.rs_id) begin
            r.value = bus.value;
            r.valid = 1'b1;
        end
        return r;
    endfunction

    // Result still waiting in the output register keeps its rs_id taken
    assign held = out_valid & ~out_ready;

    // Lowest free station
    always_comb begin
        free_idx = '0;
        unit_ready = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i] && !(held && int'(out.rs_id) == RS_OFFSET + i)) begin
                free_idx = idx_t'(i);
                unit_ready = 1'b1;
            end
        end
    end

    // Lowest station with both operands present
    always_comb begin
        sel_idx = '0;
        any_ready = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (busy[i] && op1_q[i].valid && op2_q[i].valid) begin
                sel_idx = idx_t'(i);
                any_ready = 1'b1;
            end
        end
    end

    assign free_id = rs_id_t'(RS_OFFSET + int'(free_idx));
    assign alloc = issue_valid & unit_ready;
    assign issue = any_ready & (~out_valid | out_ready);
    assign op1_in = capture(op1, snoop);
    assign op2_in = capture(op2, snoop);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (issue) begin
                busy[sel_idx] <= 1'b0;
            end
            if (alloc) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            op1_q[i] <= capture(op1_q[i], snoop);
            op2_q[i] <= capture(op2_q[i], snoop);
        end
        if (alloc) begin
            op_q[free_idx] <= op;
            addr_q[free_idx] <= result_addr;
            op1_q[free_idx] <= op1_in;
            op2_q[free_idx] <= op2_in;
        end
    end

    assign opa = op1_q[sel_idx].value;
    assign opb = op2_q[sel_idx].value;
    assign sel_op = op_q[sel_idx];

    if (UNIT == UNIT_ADD_SUB) begin : g_add_sub
        // subf computes RB - RA
        always_comb begin
            res = (sel_op == OP_SUBF) ? opb - opa : opa + opb;
        end
    end else begin : g_log
        always_comb begin
            case (sel_op)
                OP_OR: res = opa | opb;
                OP_XOR: res = opa ^ opb;
                default: res = opa & opb;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!out_valid || out_ready) begin
            out_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out.rs_id <= rs_id_t'(RS_OFFSET + int'(sel_idx));
            out.result_addr <= addr_q[sel_idx];
            out.value <= res;
        end
    end

endmodule

`default_nettype wire

//--- logic/write_back_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module write_back_arbiter
    import ppc_pkg::*;
(
    input wire logic add_sub_valid,
    output logic add_sub_ready,
    input wire unit_result_t add_sub_in,

    input wire logic log_valid,
    output logic log_ready,
    input wire unit_result_t log_in,

    output result_bus_t result
);

    unit_result_t granted;

    // Fixed priority with add/sub first
    assign add_sub_ready = add_sub_valid;
    assign log_ready = log_valid & ~add_sub_valid;
    assign granted = add_sub_valid ? add_sub_in : log_in;

    always_comb begin
        result.valid = add_sub_valid | log_valid;
        result.rs_id = granted.rs_id;
        result.result_addr = granted.result_addr;
        result.value = granted.value;
    end

endmodule

`default_nettype wire

//--- logic/ppc_core.sv
`timescale 1ns/1ps
`default_nettype none

module ppc_core
    import ppc_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input wire logic clk,
    input wire logic rst_n,

    input wire logic instruction_valid,
    output logic instruction_ready,
    input wire word_t instruction,

    output logic result_valid,
    output rs_id_t result_rs_id,
    output reg_addr_t result_reg_addr,
    output word_t result_value
);

    logic decode_valid;
    logic decode_ready;
    decode_t decode;

    logic add_sub_valid;
    logic add_sub_ready;
    rs_id_t add_sub_id;
    logic log_valid;
    logic log_ready;
    rs_id_t log_id;

    logic gpr_update_enable;
    reg_addr_t gpr_update_addr;
    rs_id_t gpr_update_rs_id;
    operand_t gpr_a;
    operand_t gpr_b;
    operand_t op1;
    operand_t op2;

    logic add_sub_out_valid;
    logic add_sub_out_ready;
    unit_result_t add_sub_out;
    logic log_out_valid;
    logic log_out_ready;
    unit_result_t log_out;
    result_bus_t result;

    instr_decode u_instr_decode (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode)
    );

    dispatcher u_dispatcher (
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode),
        .add_sub_valid(add_sub_valid),
        .add_sub_ready(add_sub_ready),
        .add_sub_id(add_sub_id),
        .log_valid(log_valid),
        .log_ready(log_ready),
        .log_id(log_id),
        .gpr_update_enable(gpr_update_enable),
        .gpr_update_addr(gpr_update_addr),
        .gpr_update_rs_id(gpr_update_rs_id)
    );

    gp_reg_file u_gp_reg_file (
        .clk(clk),
        .rst_n(rst_n),
        .read_addr_a(decode.op1_addr),
        .read_addr_b(decode.op2_addr),
        .read_a(gpr_a),
        .read_b(gpr_b),
        .update_enable(gpr_update_enable),
        .update_addr(gpr_update_addr),
        .update_rs_id(gpr_update_rs_id),
        .result(result)
    );

    // addi with RA=0 reads a literal zero
    always_comb begin
        op1 = gpr_a;
        if (decode.op1_is_zero) begin
            op1 = '{value: '0, valid: 1'b1, rs_id: '0};
        end
        op2 = gpr_b;
        if (decode.op2_use_imm) begin
            op2 = '{value: decode.immediate, valid: 1'b1, rs_id: '0};
        end
    end

    fx_unit #(
        .RS_DEPTH(RS_DEPTH),
        .RS_OFFSET(0),
        .UNIT(UNIT_ADD_SUB)
    ) u_add_sub (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(add_sub_valid),
        .unit_ready(add_sub_ready),
        .free_id(add_sub_id),
        .op(decode.op),
        .result_addr(decode.result_addr),
        .op1(op1),
        .op2(op2),
        .snoop(result),
        .out_valid(add_sub_out_valid),
        .out_ready(add_sub_out_ready),
        .out(add_sub_out)
    );

    fx_unit #(
        .RS_DEPTH(RS_DEPTH),
        .RS_OFFSET(RS_DEPTH),
        .UNIT(UNIT_LOG)
    ) u_log (
        .clk(clk),
        .rst_n(rst_n),
        .issue_valid(log_valid),
        .unit_ready(log_ready),
        .free_id(log_id),
        .op(decode.op),
        .result_addr(decode.result_addr),
        .op1(op1),
        .op2(op2),
        .snoop(result),
        .out_valid(log_out_valid),
        .out_ready(log_out_ready),
        .out(log_out)
    );

    write_back_arbiter u_write_back_arbiter (
        .add_sub_valid(add_sub_out_valid),
        .add_sub_ready(add_sub_out_ready),
        .add_sub_in(add_sub_out),
        .log_valid(log_out_valid),
        .log_ready(log_out_ready),
        .log_in(log_out),
        .result(result)
    );

    assign result_valid = result.valid;
    assign result_rs_id = result.rs_id;
    assign result_reg_addr = result.result_addr;
    assign result_value = result.value;

endmodule

`default_nettype wire

//--- dv/tb_ppc_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ppc_core;

    localparam int RS_DEPTH = 8;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int MEM_WORDS = 512;
    localparam logic [31:0] END_MARK = 32'hffffffff;
    localparam logic [31:0] NO_DEST = 32'h000000ff;

    logic clk;
    logic rst_n;
    logic instruction_valid;
    logic instruction_ready;
    logic [31:0] instruction;
    logic result_valid;
    logic [5:0] result_rs_id;
    logic [4:0] result_reg_addr;
    logic [31:0] result_value;

    // Four words per entry: test, instruction, destination, value
    logic [31:0] patterns [MEM_WORDS];

    logic [4:0] exp_addr [$];
    logic [31:0] exp_value [$];
    logic exp_is_log [$];

    int errors;
    int test_errors_base;
    int tests_run;
    logic sent_any;
    logic timed_out;
    logic [31:0] seed;

    ppc_core #(
        .RS_DEPTH(RS_DEPTH)
    ) u_ppc_core (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .result_valid(result_valid),
        .result_rs_id(result_rs_id),
        .result_reg_addr(result_reg_addr),
        .result_value(result_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Logical unit: ori, xori, and the X-form and/or/xor
    function automatic logic goes_to_log_unit(input logic [31:0] w);
        logic [5:0] opc;
        logic [9:0] xo;
        opc = w[31:26];
        xo = w[10:1];
        return (opc == 6'd24) || (opc == 6'd26)
            || (opc == 6'd31 && (xo == 10'd28 || xo == 10'd444 || xo == 10'd316));
    endfunction

    // Result bus scoreboard, sampled mid-cycle where the bus is stable
    always @(negedge clk) begin
        int idx;
        int lo;
        int hi;
        idx = -1;
        if (rst_n && result_valid) begin
            assert (sent_any) else begin
                $display("Result on the bus at %0t before any instruction was sent", $time);
                errors++;
            end
            for (int i = 0; i < exp_addr.size(); i++) begin
                if (idx < 0 && exp_addr[i] == result_reg_addr
                        && exp_value[i] == result_value) begin
                    idx = i;
                end
            end
            assert (idx >= 0) else begin
                $display("Unexpected result at %0t: register %0d value %h matches nothing",
                         $time, result_reg_addr, result_value);
                errors++;
            end
            if (idx >= 0) begin
                lo = exp_is_log[idx] ? RS_DEPTH : 0;
                hi = lo + RS_DEPTH - 1;
                assert (int'(result_rs_id) >= lo && int'(result_rs_id) <= hi) else begin
                    $display("FAILED at %0t: result_rs_id = %0d, expected %0d to %0d",
                             $time, result_rs_id, lo, hi);
                    errors++;
                end
                exp_addr.delete(idx);
                exp_value.delete(idx);
                exp_is_log.delete(idx);
            end
        end
    end

    task automatic send_instr(input logic [31:0] w);
        int cycles;
        cycles = 0;
        @(negedge clk);
        instruction_valid = 1'b1;
        instruction = w;
        sent_any = 1'b1;
        #1;
        while (!instruction_ready && cycles < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!instruction_ready) begin
            $display("Timeout at %0t: instruction %h was never accepted", $time, w);
            errors++;
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            instruction_valid = 1'b0;
        end
    endtask

    task automatic finish_test(input int num);
        int cycles;
        cycles = 0;
        @(negedge clk);
        instruction_valid = 1'b0;
        while (exp_addr.size() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        // Extra cycles to catch stray results
        repeat (10) @(negedge clk);
        assert (exp_addr.size() == 0) else begin
            $display("Test %0d ended with %0d results still missing", num, exp_addr.size());
            errors++;
        end
        exp_addr.delete();
        exp_value.delete();
        exp_is_log.delete();
        tests_run++;
        $display("test %0d finished with %0d errors", num, errors - test_errors_base);
    endtask

    initial begin
        int e;
        int cur;
        int gap;
        rst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        errors = 0;
        tests_run = 0;
        sent_any = 1'b0;
        timed_out = 1'b0;
        seed = 32'h8c5a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            patterns[i] = END_MARK;
        end
        $readmemh("dv/ppc_core_patterns.txt", patterns);

        // Test 1: reset behavior
        test_errors_base = 0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            assert (result_valid == 1'b0) else begin
                $display("FAILED at %0t: result_valid = %b, expected 0", $time, result_valid);
                errors++;
            end
        end
        rst_n = 1'b1;
        #1;
        assert (instruction_ready == 1'b1) else begin
            $display("FAILED at %0t: instruction_ready = %b, expected 1",
                     $time, instruction_ready);
            errors++;
        end
        repeat (5) @(negedge clk);
        tests_run++;
        $display("test 1 finished with %0d errors", errors);

        cur = -1;
        e = 0;
        while (4 * e + 3 < MEM_WORDS && patterns[4 * e] != END_MARK && !timed_out) begin
            if (int'(patterns[4 * e]) != cur) begin
                if (cur >= 0) begin
                    finish_test(cur);
                end
                cur = int'(patterns[4 * e]);
                test_errors_base = errors;
            end
            seed = lcg_next(seed);
            gap = int'(seed[17:16]) % 3;
            idle_cycles(gap);
            if (patterns[4 * e + 2] != NO_DEST) begin
                exp_addr.push_back(patterns[4 * e + 2][4:0]);
                exp_value.push_back(patterns[4 * e + 3]);
                exp_is_log.push_back(goes_to_log_unit(patterns[4 * e + 1]));
            end
            send_instr(patterns[4 * e + 1]);
            e++;
        end
        if (cur >= 0 && !timed_out) begin
            finish_test(cur);
        end

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ppc_core_patterns.txt
// Columns: test number, instruction word, destination GPR (ff for none), expected value
// Values follow program order starting from all GPRs at zero
02 38200005 01 00000005
02 3840fffd 02 fffffffd
02 38610100 03 00000105
02 7c811214 04 00000002
02 7ca11850 05 00000100
03 68668001 06 00008104
03 6027f0f0 07 0000f0f5
03 7c483838 08 0000f0f5
03 7c292b78 09 00000105
03 7c8a3278 0a 00008106
03 00000000 ff 00000000
03 1c200007 ff 00000000
04 39600001 0b 00000001
04 7d6b5a14 0b 00000002
04 7d6c5278 0c 00008104
04 7d6c5850 0b ffff7efe
04 618b0001 0b 00008105
04 7dab6214 0d 00010209
05 39c00007 0e 00000007
05 39ce0001 0e 00000008
05 39ce0001 0e 00000009
05 39ce0001 0e 0000000a
05 39ee0001 0f 0000000b
05 69d00001 10 0000000b
05 39ee0002 0f 0000000c
05 69d00002 10 00000008
05 39ee0003 0f 0000000d
05 69d00003 10 00000009
05 39ee0004 0f 0000000e
05 69d00004 10 0000000e
05 39ee0005 0f 0000000f
05 69d00005 10 0000000f
05 39ee0006 0f 00000010
05 69d00006 10 0000000c
05 39ee0007 0f 00000011
05 69d00007 10 0000000d
05 39ee0008 0f 00000012
05 69d00008 10 00000002
05 39ee0009 0f 00000013
05 69d00009 10 00000003

//--- sim.f
logic/ppc_pkg.sv
logic/instr_decode.sv
logic/dispatcher.sv
logic/gp_reg_file.sv
logic/fx_unit.sv
logic/write_back_arbiter.sv
logic/ppc_core.sv
dv/tb_ppc_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_ppc_core
RTL_TOP ?= ppc_core
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^\*\*\* PASSED \*\*\*$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(filter logic/%,$(shell cat $(FILELIST)))

clean:
	rm -rf $(BUILD_DIR) $(LOG)
